// File: logic/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Width of the clocks-per-bit divisor.
`define UART_DIV_W 16

// Clocks per bit out of reset, 50 MHz at 115200 baud.
`define UART_DIV_RESET 434

// Register address width.
`define UART_ADDR_W 2

`endif

// File: logic/uart_line_pkg.sv
`include "uart_cfg.svh"

package uart_line_pkg;

	typedef logic [7:0] uart_byte_t;
	typedef logic [2:0] bit_index_t;
	typedef logic [`UART_DIV_W-1:0] baud_div_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

endpackage

// File: logic/uart_regs_pkg.sv
`include "uart_cfg.svh"

package uart_regs_pkg;

	import uart_line_pkg::*;

	typedef logic [`UART_ADDR_W-1:0] reg_addr_t;

	localparam reg_addr_t REG_CTRL = 2'd0;
	localparam reg_addr_t REG_DIV = 2'd1;
	localparam reg_addr_t REG_STATUS = 2'd2;

	// Settings that steer both directions.
	typedef struct packed {
		logic parity_en;
		logic parity_odd;
		baud_div_t divisor;
	} uart_ctrl_t;

	// Readback layout, tx_busy in bit 0.
	typedef struct packed {
		logic parity_error;
		logic frame_error;
		logic tx_busy;
	} uart_status_t;

endpackage

// File: logic/uart_timer.sv
module uart_timer import uart_line_pkg::*;
(
	input logic clk,
	input logic async_nreset,
	input logic enable,
	input logic clear,
	input baud_div_t divisor,
	output logic tick,
	output logic half_tick
);

	baud_div_t count;

	// End of a bit period.
	assign tick = enable && (count == divisor - baud_div_t'(1));

	// Middle of a bit period.
	assign half_tick = enable && (count == (divisor >> 1));

	always_ff @(posedge clk or negedge async_nreset)
	begin
		if (!async_nreset)
		begin
			count <= '0;
		end
		else if (clear || tick)
		begin
			count <= '0;
		end
		else if (enable)
		begin
			count <= count + baud_div_t'(1);
		end
	end

endmodule

// File: logic/uart_tx.sv
module uart_tx import uart_line_pkg::*, uart_regs_pkg::*;
(
	input logic clk,
	input logic async_nreset,
	input uart_ctrl_t ctrl,
	input uart_byte_t data_in,
	input logic data_valid,
	output logic tx,
	output logic tx_busy
);

	tx_state_t state_reg, state_next;
	bit_index_t index_reg, index_next;
	uart_byte_t data_reg;
	uart_ctrl_t ctrl_reg;
	logic accept;
	logic timer_enable;
	logic timer_tick;
	logic parity_bit;

	// Timer runs only inside a frame.
	assign timer_enable = (state_reg != TX_IDLE);

	uart_timer bit_timer
	(
		.clk(clk),
		.async_nreset(async_nreset),
		.enable(timer_enable),
		.clear(!timer_enable),
		.divisor(ctrl_reg.divisor),
		.tick(timer_tick),
		.half_tick()
	);

	assign accept = (state_reg == TX_IDLE) && data_valid;
	assign parity_bit = (^data_reg) ^ ctrl_reg.parity_odd;
	assign tx_busy = timer_enable;

	always_comb
	begin
		state_next = state_reg;
		index_next = index_reg;
		case (state_reg)
			TX_IDLE:
				if (accept)
					state_next = TX_START;
			TX_START:
				if (timer_tick)
				begin
					state_next = TX_DATA;
					index_next = '0;
				end
			TX_DATA:
				if (timer_tick)
				begin
					if (index_reg == bit_index_t'(7))
						state_next = ctrl_reg.parity_en ? TX_PARITY : TX_STOP;
					else
						index_next = index_reg + bit_index_t'(1);
				end
			TX_PARITY:
				if (timer_tick)
					state_next = TX_STOP;
			TX_STOP:
				if (timer_tick)
					state_next = TX_IDLE;
			default:
				state_next = TX_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge async_nreset)
	begin
		if (!async_nreset)
		begin
			state_reg <= TX_IDLE;
			index_reg <= '0;
		end
		else
		begin
			state_reg <= state_next;
			index_reg <= index_next;
		end
	end

	// Byte and settings held for the whole frame.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			data_reg <= data_in;
			ctrl_reg <= ctrl;
		end
	end

	always_comb
	begin
		case (state_reg)
			TX_START: tx = 1'b0;
			TX_DATA: tx = data_reg[index_reg];
			TX_PARITY: tx = parity_bit;
			default: tx = 1'b1;
		endcase
	end

endmodule

// File: logic/uart_rx.sv
module uart_rx import uart_line_pkg::*, uart_regs_pkg::*;
(
	input logic clk,
	input logic async_nreset,
	input uart_ctrl_t ctrl,
	input logic rx,
	output uart_byte_t rx_data,
	output logic rx_valid,
	output logic err_parity,
	output logic err_frame
);

	rx_state_t state_reg, state_next;
	bit_index_t index_reg, index_next;
	uart_byte_t data_reg;
	uart_ctrl_t ctrl_reg;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic parity_reg;
	logic start_edge;
	logic timer_enable;
	logic timer_tick;
	logic timer_half;
	logic frame_done;
	logic parity_bad;

	assign timer_enable = (state_reg != RX_IDLE);

	uart_timer bit_timer
	(
		.clk(clk),
		.async_nreset(async_nreset),
		.enable(timer_enable),
		.clear(!timer_enable),
		.divisor(ctrl_reg.divisor),
		.tick(timer_tick),
		.half_tick(timer_half)
	);

	// Line idles high, so the flops reset to 1.
	always_ff @(posedge clk or negedge async_nreset)
	begin
		if (!async_nreset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign start_edge = rx_prev && !rx_sync;
	assign frame_done = (state_reg == RX_STOP) && timer_half;
	assign parity_bad = ctrl_reg.parity_en &&
		(parity_reg != ((^data_reg) ^ ctrl_reg.parity_odd));
	assign rx_data = data_reg;

	always_comb
	begin
		state_next = state_reg;
		index_next = index_reg;
		case (state_reg)
			RX_IDLE:
				if (start_edge)
					state_next = RX_START;
			RX_START:
				// False start if the line is back high mid-bit.
				if (timer_half && rx_sync)
					state_next = RX_IDLE;
				else if (timer_tick)
				begin
					state_next = RX_DATA;
					index_next = '0;
				end
			RX_DATA:
				if (timer_tick)
				begin
					if (index_reg == bit_index_t'(7))
						state_next = ctrl_reg.parity_en ? RX_PARITY : RX_STOP;
					else
						index_next = index_reg + bit_index_t'(1);
				end
			RX_PARITY:
				if (timer_tick)
					state_next = RX_STOP;
			RX_STOP:
				if (timer_half)
					state_next = RX_IDLE;
			default:
				state_next = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge async_nreset)
	begin
		if (!async_nreset)
		begin
			state_reg <= RX_IDLE;
			index_reg <= '0;
			rx_valid <= 1'b0;
			err_parity <= 1'b0;
			err_frame <= 1'b0;
		end
		else
		begin
			state_reg <= state_next;
			index_reg <= index_next;
			rx_valid <= frame_done;
			err_parity <= frame_done && parity_bad;
			err_frame <= frame_done && !rx_sync;
		end
	end

	// Data shifts in LSB first at mid-bit.
	always_ff @(posedge clk)
	begin
		if ((state_reg == RX_IDLE) && start_edge)
			ctrl_reg <= ctrl;
		if ((state_reg == RX_DATA) && timer_half)
			data_reg <= {rx_sync, data_reg[7:1]};
		if ((state_reg == RX_PARITY) && timer_half)
			parity_reg <= rx_sync;
	end

endmodule

// File: logic/uart_config.sv
`include "uart_cfg.svh"

module uart_config import uart_line_pkg::*, uart_regs_pkg::*;
(
	input logic clk,
	input logic async_nreset,
	input logic cfg_write,
	input reg_addr_t cfg_addr,
	input logic [15:0] cfg_wdata,
	output logic [15:0] cfg_rdata,
	output uart_ctrl_t ctrl,
	input logic err_parity,
	input logic err_frame,
	input logic tx_busy
);

	localparam baud_div_t DIV_MIN = baud_div_t'(4);

	uart_ctrl_t ctrl_reg;
	uart_status_t status;
	uart_status_t clear_mask;
	logic parity_sticky;
	logic frame_sticky;
	logic write_ctrl;
	logic write_div;
	logic write_status;

	assign write_ctrl = cfg_write && (cfg_addr == REG_CTRL);
	assign write_div = cfg_write && (cfg_addr == REG_DIV);
	assign write_status = cfg_write && (cfg_addr == REG_STATUS);
	assign clear_mask = write_status ?
		uart_status_t'(cfg_wdata[$bits(uart_status_t)-1:0]) : '0;

	always_ff @(posedge clk or negedge async_nreset)
	begin
		if (!async_nreset)
		begin
			ctrl_reg <= '{parity_en: 1'b0, parity_odd: 1'b0,
				divisor: baud_div_t'(`UART_DIV_RESET)};
			parity_sticky <= 1'b0;
			frame_sticky <= 1'b0;
		end
		else
		begin
			if (write_ctrl)
			begin
				ctrl_reg.parity_en <= cfg_wdata[0];
				ctrl_reg.parity_odd <= cfg_wdata[1];
			end
			// Too small a divisor leaves no room for a mid-bit sample.
			if (write_div)
				ctrl_reg.divisor <= (baud_div_t'(cfg_wdata) < DIV_MIN) ?
					DIV_MIN : baud_div_t'(cfg_wdata);
			// Set wins over clear.
			parity_sticky <= err_parity || (parity_sticky && !clear_mask.parity_error);
			frame_sticky <= err_frame || (frame_sticky && !clear_mask.frame_error);
		end
	end

	assign ctrl = ctrl_reg;
	assign status = '{parity_error: parity_sticky, frame_error: frame_sticky,
		tx_busy: tx_busy};

	always_comb
	begin
		cfg_rdata = '0;
		case (cfg_addr)
			REG_CTRL: cfg_rdata[1:0] = {ctrl_reg.parity_odd, ctrl_reg.parity_en};
			REG_DIV: cfg_rdata = 16'(ctrl_reg.divisor);
			REG_STATUS: cfg_rdata[$bits(uart_status_t)-1:0] = status;
			default: cfg_rdata = '0;
		endcase
	end

endmodule

// File: logic/uart_top.sv
module uart_top import uart_line_pkg::*, uart_regs_pkg::*;
(
	input logic clk,
	input logic async_nreset,
	input logic cfg_write,
	input reg_addr_t cfg_addr,
	input logic [15:0] cfg_wdata,
	output logic [15:0] cfg_rdata,
	input uart_byte_t data_in,
	input logic data_valid,
	output logic tx,
	output logic tx_busy,
	input logic rx,
	output uart_byte_t rx_data,
	output logic rx_valid
);

	uart_ctrl_t ctrl;
	logic err_parity;
	logic err_frame;

	uart_config config_block
	(
		.clk(clk),
		.async_nreset(async_nreset),
		.cfg_write(cfg_write),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.ctrl(ctrl),
		.err_parity(err_parity),
		.err_frame(err_frame),
		.tx_busy(tx_busy)
	);

	uart_tx transmitter
	(
		.clk(clk),
		.async_nreset(async_nreset),
		.ctrl(ctrl),
		.data_in(data_in),
		.data_valid(data_valid),
		.tx(tx),
		.tx_busy(tx_busy)
	);

	uart_rx receiver
	(
		.clk(clk),
		.async_nreset(async_nreset),
		.ctrl(ctrl),
		.rx(rx),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.err_parity(err_parity),
		.err_frame(err_frame)
	);

endmodule

// File: verification/uart_top_chk.sv
module uart_top_chk
(
	input logic clk,
	input logic async_nreset,
	input logic tx,
	input logic tx_busy,
	input logic rx_valid,
	input logic err_parity,
	input logic err_frame
);

	// Line idles high between frames.
	idle_line_high: assert property (@(posedge clk) disable iff (!async_nreset)
		!tx_busy |-> tx)
	else
		$error("tx is low while the transmitter is idle");

	valid_single_cycle: assert property (@(posedge clk) disable iff (!async_nreset)
		rx_valid |=> !rx_valid)
	else
		$error("rx_valid stayed high for more than one cycle");

	error_with_valid: assert property (@(posedge clk) disable iff (!async_nreset)
		(err_parity || err_frame) |-> rx_valid)
	else
		$error("receive error pulse without rx_valid");

endmodule

bind uart_top uart_top_chk chk
(
	.clk(clk),
	.async_nreset(async_nreset),
	.tx(tx),
	.tx_busy(tx_busy),
	.rx_valid(rx_valid),
	.err_parity(err_parity),
	.err_frame(err_frame)
);

// File: verification/uart_top_tb.sv
`include "uart_cfg.svh"

module uart_top_tb import uart_line_pkg::*, uart_regs_pkg::*;
();

	localparam int DIV = 8;
	localparam int NUM_FRAMES = 20;
	// Frames plus setup at 11 bits each and twice that for margin.
	localparam int WATCHDOG = (NUM_FRAMES + 4) * 11 * DIV * 10 * 2;

	logic clk;
	logic async_nreset;
	logic cfg_write;
	reg_addr_t cfg_addr;
	logic [15:0] cfg_wdata;
	logic [15:0] cfg_rdata;
	uart_byte_t data_in;
	uart_byte_t rx_data;
	logic data_valid;
	logic tx;
	logic tx_busy;
	logic rx;
	logic rx_valid;
	logic loopback;
	logic rx_drive;
	int seed;
	int errors;
	int sent;
	int received;
	uart_byte_t expected_q[$];

	assign rx = loopback ? tx : rx_drive;

	uart_top dut
	(
		.clk(clk),
		.async_nreset(async_nreset),
		.cfg_write(cfg_write),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.data_in(data_in),
		.data_valid(data_valid),
		.tx(tx),
		.tx_busy(tx_busy),
		.rx(rx),
		.rx_data(rx_data),
		.rx_valid(rx_valid)
	);

	always #5 clk = ~clk;

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected)
		else
		begin
			errors++;
			$display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond)
		else
		begin
			errors++;
			$display("Error at %0t: %s", $time, what);
		end
	endtask

	task automatic write_reg(input reg_addr_t addr, input logic [15:0] data);
		cfg_addr = addr;
		cfg_wdata = data;
		cfg_write = 1'b1;
		@(posedge clk);
		#1;
		cfg_write = 1'b0;
	endtask

	task automatic read_reg(input reg_addr_t addr, output logic [15:0] value);
		cfg_addr = addr;
		@(negedge clk);
		value = cfg_rdata;
		@(posedge clk);
		#1;
	endtask

	// Start in bit 0, data LSB first, optional parity, stop; unused bits high.
	function automatic logic [10:0] model_frame(input uart_byte_t value,
		input logic par_en, input logic par_odd);
		logic [10:0] bits;
		logic parity;
		int i;
		parity = par_odd;
		for (i = 0; i < 8; i++)
			parity = parity ^ value[i];
		bits = '1;
		bits[0] = 1'b0;
		bits[8:1] = value;
		if (par_en)
			bits[9] = parity;
		return bits;
	endfunction

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (tx_busy && cycles < 2 * DIV)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		check_true(!tx_busy, "transmitter still busy after the stop bit");
	endtask

	// Samples tx mid-bit; inject pulses data_valid during the data bits.
	task automatic send_frame(input logic par_en, input logic par_odd, input logic inject);
		uart_byte_t value;
		logic [10:0] bits;
		int length;
		int i;
		write_reg(REG_CTRL, {14'd0, par_odd, par_en});
		value = uart_byte_t'($random(seed));
		bits = model_frame(value, par_en, par_odd);
		length = par_en ? 11 : 10;
		expected_q.push_back(value);
		sent++;
		data_in = value;
		data_valid = 1'b1;
		@(posedge clk);
		#1;
		data_valid = 1'b0;
		check_true(tx_busy, "transmitter did not start the frame");
		repeat (DIV / 2) @(posedge clk);
		#1;
		for (i = 0; i < length; i++)
		begin
			if (i > 0)
			begin
				@(posedge clk);
				#1;
				data_valid = 1'b0;
				repeat (DIV - 1) @(posedge clk);
				#1;
			end
			check_value($sformatf("tx bit %0d", i), 16'(bits[i]), 16'(tx));
			if (inject && i == 3)
			begin
				data_valid = 1'b1;
				data_in = uart_byte_t'($random(seed));
			end
		end
		wait_idle();
	endtask

	task automatic drive_rx(input logic par_en, input logic par_odd,
		input logic flip_parity, input logic stop_bit);
		uart_byte_t value;
		logic [10:0] bits;
		int length;
		int i;
		write_reg(REG_CTRL, {14'd0, par_odd, par_en});
		value = uart_byte_t'($random(seed));
		bits = model_frame(value, par_en, par_odd);
		length = par_en ? 11 : 10;
		if (flip_parity)
			bits[9] = ~bits[9];
		bits[length - 1] = stop_bit;
		expected_q.push_back(value);
		sent++;
		for (i = 0; i <= length; i++)
		begin
			rx_drive = (i < length) ? bits[i] : 1'b1;
			repeat (DIV) @(posedge clk);
			#1;
		end
	endtask

	always @(negedge clk)
	begin
		if (async_nreset && rx_valid)
		begin
			received++;
			if (expected_q.size() == 0)
				check_true(1'b0, "receiver produced a byte that was never sent");
			else
				check_value("rx_data", 16'(expected_q.pop_front()), 16'(rx_data));
		end
	end

	initial
	begin
		#(WATCHDOG);
		$display("Watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		logic [15:0] value;
		logic [31:0] pick;
		int n;
		clk = 1'b0;
		async_nreset = 1'b0;
		cfg_write = 1'b0;
		cfg_addr = REG_CTRL;
		cfg_wdata = '0;
		data_in = '0;
		data_valid = 1'b0;
		rx_drive = 1'b1;
		loopback = 1'b1;
		seed = 32'h20405616;
		errors = 0;
		sent = 0;
		received = 0;
		repeat (16) @(posedge clk);
		#1;
		async_nreset = 1'b1;

		check_value("tx", 16'd1, 16'(tx));
		check_value("tx_busy", 16'd0, 16'(tx_busy));
		read_reg(REG_DIV, value);
		check_value("REG_DIV", 16'(`UART_DIV_RESET), value);
		write_reg(REG_DIV, 16'd2);
		read_reg(REG_DIV, value);
		check_value("REG_DIV", 16'd4, value);
		write_reg(REG_CTRL, 16'd3);
		read_reg(REG_CTRL, value);
		check_value("REG_CTRL", 16'd3, value);
		write_reg(REG_DIV, 16'(DIV));
		read_reg(REG_DIV, value);
		check_value("REG_DIV", 16'(DIV), value);

		// Loopback with random parity settings and busy pulses.
		for (n = 0; n < NUM_FRAMES; n++)
		begin
			pick = $random(seed);
			send_frame(pick[0], pick[1], pick[2]);
			repeat (2) @(posedge clk);
			#1;
		end
		repeat (2 * DIV) @(posedge clk);
		#1;
		check_value("received frames", 16'(sent), 16'(received));
		read_reg(REG_STATUS, value);
		check_value("REG_STATUS errors", 16'd0, value & 16'h6);

		loopback = 1'b0;
		drive_rx(1'b1, pick[3], 1'b1, 1'b1);
		read_reg(REG_STATUS, value);
		check_value("REG_STATUS parity_error", 16'd1, 16'(value[2]));
		write_reg(REG_STATUS, 16'h4);
		read_reg(REG_STATUS, value);
		check_value("REG_STATUS parity_error", 16'd0, 16'(value[2]));

		drive_rx(1'b0, 1'b0, 1'b0, 1'b0);
		read_reg(REG_STATUS, value);
		check_value("REG_STATUS frame_error", 16'd1, 16'(value[1]));
		write_reg(REG_STATUS, 16'h2);
		read_reg(REG_STATUS, value);
		check_value("REG_STATUS frame_error", 16'd0, 16'(value[1]));
		check_value("received frames", 16'(sent), 16'(received));

		$display("Run finished with %0d errors, %0d frames sent, %0d received",
			errors, sent, received);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: uart_top.f
+incdir+logic
logic/uart_line_pkg.sv
logic/uart_regs_pkg.sv
logic/uart_timer.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_config.sv
logic/uart_top.sv
verification/uart_top_chk.sv
verification/uart_top_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f uart_top.f --top-module uart_top_tb
	./obj_dir/Vuart_top_tb | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
